// ==== mul_sub.f ====
src/mul_pkg.sv
src/partial_product.sv
src/pipelined_multiplier.sv
src/stream_fifo.sv
src/mul_top.sv
tb/tb_mul_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_mul_top \
  -Mdir obj_dir \
  -o sim_tb \
  -f mul_sub.f

output="$(./obj_dir/sim_tb)"
echo "$output"

if grep -qF -- '** PASS **' <<< "$output"; then
  echo "Simulation result: passed"
  exit 0
else
  echo "Simulation result: failed"
  exit 1
fi

// ==== src/mul_pkg.sv ====
package mul_pkg;

  // ****************************************
  // Operand and product widths
  // ****************************************

  localparam int BW_INPUT   = 32;
  localparam int BW_PRODUCT = 2 * BW_INPUT;

  // Right operand cut in two halves, then each half in two again
  localparam int BW_HALF_LO = (BW_INPUT + 1) >> 1;
  localparam int BW_HALF_HI = BW_INPUT - BW_HALF_LO;

  localparam int BW_CHUNK0 = (BW_HALF_LO + 1) >> 1;
  localparam int BW_CHUNK1 = BW_HALF_LO - BW_CHUNK0;
  localparam int BW_CHUNK2 = (BW_HALF_HI + 1) >> 1;
  localparam int BW_CHUNK3 = BW_HALF_HI - BW_CHUNK2;

  // Bit position of each chunk inside the right operand
  localparam int SHIFT1 = BW_CHUNK0;
  localparam int SHIFT2 = SHIFT1 + BW_CHUNK1;
  localparam int SHIFT3 = SHIFT2 + BW_CHUNK2;

  // Whole left operand times one extended chunk
  localparam int BW_PP = BW_INPUT + BW_CHUNK0 + 1;

  // ****************************************
  // Stream buffering
  // ****************************************

  localparam int FIFO_DEPTH  = 4;
  localparam int BW_FIFO_PTR = $clog2(FIFO_DEPTH);
  localparam int BW_FIFO_CNT = $clog2(FIFO_DEPTH + 1);

  // Left operand above right operand
  localparam int BW_PAIR = 2 * BW_INPUT;

  typedef logic signed [BW_INPUT-1:0] operand_t;

  // Product seen as one signed value or as two halves
  typedef union packed {
    logic signed [BW_PRODUCT-1:0] full;
    struct packed {
      logic [BW_INPUT-1:0] upper;
      logic [BW_INPUT-1:0] lower;
    } halves;
  } product_t;

endpackage

// ==== src/mul_top.sv ====
`timescale 1ns/1ps

module mul_top
(
  input  logic              clk,
  input  logic              rstnn,
  input  logic              stall,

  input  logic              in_valid,
  output logic              in_ready,
  input  mul_pkg::operand_t in_left,
  input  mul_pkg::operand_t in_right,

  output logic              out_valid,
  input  logic              out_ready,
  output mul_pkg::product_t out_product
);

  // Operand pair from input FIFO to multiplier
  logic                         pair_valid;
  logic                         pair_ready;
  logic [mul_pkg::BW_PAIR-1:0]  pair;

  // Product from multiplier to output FIFO
  logic                         prod_valid;
  logic                         prod_ready;
  mul_pkg::product_t            prod;

  stream_fifo i_in_fifo
  (
    .clk     (clk),
    .rstnn   (rstnn),
    .wr_valid(in_valid),
    .wr_ready(in_ready),
    .wr_data ({in_left, in_right}),
    .rd_valid(pair_valid),
    .rd_ready(pair_ready),
    .rd_data (pair)
  );

  pipelined_multiplier i_mult
  (
    .clk        (clk),
    .rstnn      (rstnn),
    .stall      (stall),
    .op_valid   (pair_valid),
    .op_ready   (pair_ready),
    .op_left    (pair[mul_pkg::BW_PAIR-1:mul_pkg::BW_INPUT]),
    .op_right   (pair[mul_pkg::BW_INPUT-1:0]),
    .res_valid  (prod_valid),
    .res_ready  (prod_ready),
    .res_product(prod)
  );

  stream_fifo i_out_fifo
  (
    .clk     (clk),
    .rstnn   (rstnn),
    .wr_valid(prod_valid),
    .wr_ready(prod_ready),
    .wr_data (prod),
    .rd_valid(out_valid),
    .rd_ready(out_ready),
    .rd_data (out_product)
  );

endmodule

// ==== src/partial_product.sv ====
`timescale 1ns/1ps

// One multiplier cell: whole left operand by one chunk of the right operand
module partial_product
(
  input  logic signed [mul_pkg::BW_INPUT-1:0] multiplicand,
  input  logic signed [mul_pkg::BW_CHUNK0:0]  multiplier,
  output logic signed [mul_pkg::BW_PP-1:0]    product
);

  logic signed [mul_pkg::BW_PP-1:0] multiplicand_ext;
  logic signed [mul_pkg::BW_PP-1:0] multiplier_ext;

  // Sign extension to the product width
  // Lower chunks already carry a zero top bit, the top chunk its sign
  assign multiplicand_ext = mul_pkg::BW_PP'(multiplicand);
  assign multiplier_ext   = mul_pkg::BW_PP'(multiplier);

  // Result fits exactly, nothing is lost in the truncation
  assign product = multiplicand_ext * multiplier_ext;

endmodule

// ==== src/pipelined_multiplier.sv ====
`timescale 1ns/1ps

module pipelined_multiplier
(
  input  logic              clk,
  input  logic              rstnn,
  input  logic              stall,

  input  logic              op_valid,
  output logic              op_ready,
  input  mul_pkg::operand_t op_left,
  input  mul_pkg::operand_t op_right,

  output logic              res_valid,
  input  logic              res_ready,
  output mul_pkg::product_t res_product
);

  logic                               accept;
  logic                               drain;
  logic                               held;

  logic [mul_pkg::BW_CHUNK0-1:0]      chunk0;
  logic [mul_pkg::BW_CHUNK1-1:0]      chunk1;
  logic [mul_pkg::BW_CHUNK2-1:0]      chunk2;
  logic [mul_pkg::BW_CHUNK3-1:0]      chunk3;

  logic signed [mul_pkg::BW_PP-1:0]   pp0, pp1, pp2, pp3;
  logic signed [mul_pkg::BW_PP-1:0]   pp0_q, pp1_q, pp2_q, pp3_q;
  logic signed [mul_pkg::BW_PRODUCT-1:0] term0, term1, term2, term3;

  // ****************************************
  // Handshake
  // ****************************************

  // Output register leaves this cycle
  assign drain    = ~stall & res_ready;
  assign op_ready = ~stall & (~held | drain);
  assign accept   = op_valid & op_ready;

  assign res_valid = held & ~stall;

  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
      held <= 1'b0;
    else if (accept)
      held <= 1'b1;
    else if (held & drain)
      held <= 1'b0;
  end

  // ****************************************
  // Partial products
  // ****************************************

  assign {chunk3, chunk2, chunk1, chunk0} = op_right;

  partial_product i_pp0
  (
    .multiplicand(op_left),
    .multiplier  ({1'b0, chunk0}),
    .product     (pp0)
  );

  partial_product i_pp1
  (
    .multiplicand(op_left),
    .multiplier  ({1'b0, chunk1}),
    .product     (pp1)
  );

  partial_product i_pp2
  (
    .multiplicand(op_left),
    .multiplier  ({1'b0, chunk2}),
    .product     (pp2)
  );

  // Top chunk holds the sign of the right operand
  partial_product i_pp3
  (
    .multiplicand(op_left),
    .multiplier  ({chunk3[mul_pkg::BW_CHUNK3-1], chunk3}),
    .product     (pp3)
  );

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      pp0_q <= pp0;
      pp1_q <= pp1;
      pp2_q <= pp2;
      pp3_q <= pp3;
    end
  end

  // ****************************************
  // Shift and add
  // ****************************************

  assign term0 = mul_pkg::BW_PRODUCT'(pp0_q);
  assign term1 = mul_pkg::BW_PRODUCT'(pp1_q) <<< mul_pkg::SHIFT1;
  assign term2 = mul_pkg::BW_PRODUCT'(pp2_q) <<< mul_pkg::SHIFT2;
  assign term3 = mul_pkg::BW_PRODUCT'(pp3_q) <<< mul_pkg::SHIFT3;

  always_comb
  begin
    res_product.full = term0 + term1 + term2 + term3;
  end

  // A product held under back-pressure stays put while not stalled
  a_hold_product: assert property (@(posedge clk) disable iff (!rstnn)
    (res_valid && !res_ready && !stall) ##1 !stall |-> res_valid && $stable(res_product));

  // A stalled stage neither takes a new pair nor loses the one it holds
  a_stall_blocks: assert property (@(posedge clk) disable iff (!rstnn)
    stall |=> $stable(held) && (!held || $stable(res_product)));

endmodule

// ==== src/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo
(
  input  logic                             clk,
  input  logic                             rstnn,

  input  logic                             wr_valid,
  output logic                             wr_ready,
  input  logic [mul_pkg::BW_PRODUCT-1:0]   wr_data,

  output logic                             rd_valid,
  input  logic                             rd_ready,
  output logic [mul_pkg::BW_PRODUCT-1:0]   rd_data
);

  logic [mul_pkg::BW_PRODUCT-1:0]  mem [mul_pkg::FIFO_DEPTH];
  logic [mul_pkg::BW_PRODUCT-1:0]  head_q;
  logic [mul_pkg::BW_FIFO_PTR-1:0] wr_ptr, rd_ptr, rd_ptr_nxt;
  logic [mul_pkg::BW_FIFO_CNT-1:0] count, count_nxt;
  logic                            do_wr, do_rd;
  logic                            rd_valid_q, wr_ready_q;

  assign do_wr = wr_valid & wr_ready_q;
  assign do_rd = rd_valid_q & rd_ready;

  assign rd_ptr_nxt = rd_ptr + mul_pkg::BW_FIFO_PTR'(do_rd);

  always_comb
  begin
    case ({do_wr, do_rd})
      2'b10:   count_nxt = count + mul_pkg::BW_FIFO_CNT'(1);
      2'b01:   count_nxt = count - mul_pkg::BW_FIFO_CNT'(1);
      default: count_nxt = count;
    endcase
  end

  // Pointers, occupancy and both handshake flags
  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      rd_valid_q <= 1'b0;
      wr_ready_q <= 1'b1;
    end
    else
    begin
      wr_ptr     <= wr_ptr + mul_pkg::BW_FIFO_PTR'(do_wr);
      rd_ptr     <= rd_ptr_nxt;
      count      <= count_nxt;
      rd_valid_q <= (count_nxt != '0);
      wr_ready_q <= (count_nxt != mul_pkg::BW_FIFO_CNT'(mul_pkg::FIFO_DEPTH));
    end
  end

  // Head register follows the next oldest entry
  // A write landing on an emptied FIFO goes straight into it
  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_data;
    if (do_wr && (wr_ptr == rd_ptr_nxt))
      head_q <= wr_data;
    else
      head_q <= mem[rd_ptr_nxt];
  end

  assign wr_ready = wr_ready_q;
  assign rd_valid = rd_valid_q;
  assign rd_data  = head_q;

  a_no_write_full: assert property (@(posedge clk) disable iff (!rstnn)
    (count == mul_pkg::BW_FIFO_CNT'(mul_pkg::FIFO_DEPTH)) |-> !do_wr);

  a_valid_count: assert property (@(posedge clk) disable iff (!rstnn)
    rd_valid == (count != '0));

endmodule

// ==== tb/tb_mul_top.sv ====
`timescale 1ns/1ps

module tb_mul_top;

  localparam int TIMEOUT = 1000;

  logic              clk = 1'b0;
  logic              rstnn;
  logic              stall = 1'b0;
  logic              in_valid;
  logic              in_ready;
  mul_pkg::operand_t in_left;
  mul_pkg::operand_t in_right;
  logic              out_valid;
  logic              out_ready = 1'b1;
  mul_pkg::product_t out_product;

  // Expected products in order of acceptance
  mul_pkg::product_t exp_q[$];
  mul_pkg::product_t mon_expected;

  // 0 steady, 1 random
  int    stall_mode = 0;
  // 0 high, 1 random, 2 low
  int    ready_mode = 0;
  int    error_count = 0;
  int    pass_count = 0;
  int    fail_count = 0;
  int    in_wait_cycles = 0;
  bit    timed_out = 1'b0;
  string test_name = "reset";

  mul_top i_dut
  (
    .clk        (clk),
    .rstnn      (rstnn),
    .stall      (stall),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_left    (in_left),
    .in_right   (in_right),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_product(out_product)
  );

  always #2 clk = ~clk;

  // ****************************************
  // Model and compare tasks
  // ****************************************

  // Signed product of the sign-extended operands
  function automatic mul_pkg::product_t model_product(input mul_pkg::operand_t l,
                                                      input mul_pkg::operand_t r);
    mul_pkg::product_t p;
    p.full = longint'(l) * longint'(r);
    return p;
  endfunction

  task automatic check_product(input mul_pkg::product_t got, input mul_pkg::product_t exp);
    if (got.full !== exp.full)
    begin
      $display("error %0t %s: product %h, expected %h", $time, test_name, got.full, exp.full);
      error_count++;
    end
    if (got.halves.upper !== exp.full[mul_pkg::BW_PRODUCT-1:mul_pkg::BW_INPUT])
    begin
      $display("error %0t %s: upper half %h is wrong", $time, test_name, got.halves.upper);
      error_count++;
    end
    if (got.halves.lower !== exp.full[mul_pkg::BW_INPUT-1:0])
    begin
      $display("error %0t %s: lower half %h is wrong", $time, test_name, got.halves.lower);
      error_count++;
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
    begin
      $display("error %0t %s: %s is %0d, expected %0d", $time, test_name, what, got, exp);
      error_count++;
    end
  endtask

  task automatic note_timeout(input string what);
    timed_out = 1'b1;
    $display("Test %s timed out waiting for %s", test_name, what);
  endtask

  task automatic report_test(input int errors_before);
    if (timed_out || error_count != errors_before)
    begin
      fail_count++;
      $display("test %s: failed", test_name);
    end
    else
    begin
      pass_count++;
      $display("test %s: passed", test_name);
    end
  endtask

  // ****************************************
  // Stimulus and receiver
  // ****************************************

  // Background drive of stall and out_ready
  always @(posedge clk)
  begin
    stall <= (stall_mode == 1) ? (($urandom % 4) == 0) : 1'b0;
    case (ready_mode)
      1:       out_ready <= ($urandom % 2) != 0;
      2:       out_ready <= 1'b0;
      default: out_ready <= 1'b1;
    endcase
  end

  always @(posedge clk)
  begin
    if (rstnn && out_valid && out_ready)
    begin
      if (exp_q.size() == 0)
      begin
        $display("error %0t %s: product arrived with none outstanding", $time, test_name);
        error_count++;
      end
      else
      begin
        mon_expected = exp_q.pop_front();
        check_product(out_product, mon_expected);
      end
    end
    if (rstnn && in_valid && in_ready)
      exp_q.push_back(model_product(in_left, in_right));
  end

  // Returns on the edge where the pair is taken
  task automatic send_pair(input mul_pkg::operand_t l, input mul_pkg::operand_t r);
    int t;
    in_valid <= 1'b1;
    in_left  <= l;
    in_right <= r;
    t = 0;
    @(posedge clk);
    while (!in_ready && !timed_out)
    begin
      in_wait_cycles++;
      t++;
      if (t >= TIMEOUT)
        note_timeout("in_ready");
      else
        @(posedge clk);
    end
  endtask

  task automatic wait_drain();
    int t;
    in_valid <= 1'b0;
    t = 0;
    do
    begin
      @(negedge clk);
      t++;
    end
    while (exp_q.size() != 0 && t < TIMEOUT);
    if (exp_q.size() != 0)
      note_timeout("the remaining products");
    @(posedge clk);
  endtask

  // ****************************************
  // Tests
  // ****************************************

  task automatic test_corners();
    int errors_before;
    errors_before = error_count;
    test_name = "corner products";
    send_pair(32'sd0, 32'sh1234_5678);
    send_pair(32'sd1, -32'sd1);
    send_pair(-32'sd1, -32'sd1);
    send_pair(32'sh8000_0000, -32'sd1);
    send_pair(32'sh8000_0000, 32'sh8000_0000);
    send_pair(32'sh7fff_ffff, 32'sh7fff_ffff);
    // Only one chunk nonzero on each side
    send_pair(32'sh0000_00ff, 32'shff00_0000);
    send_pair(32'sh00a5_0000, 32'sh0000_5a00);
    send_pair(32'sh8100_0000, 32'sh0081_0000);
    wait_drain();
    report_test(errors_before);
  endtask

  task automatic test_streaming();
    int errors_before;
    int cycles;
    int waits_before;
    errors_before = error_count;
    test_name = "latency and streaming";
    send_pair($urandom, $urandom);
    in_valid <= 1'b0;
    cycles = 0;
    do
    begin
      @(posedge clk);
      cycles++;
    end
    while (!out_valid && cycles < TIMEOUT);
    if (!out_valid)
      note_timeout("out_valid");
    check_count(cycles, 3, "latency in cycles");
    wait_drain();
    waits_before = in_wait_cycles;
    repeat (200)
      send_pair($urandom, $urandom);
    check_count(in_wait_cycles - waits_before, 0, "cycles with in_ready low");
    wait_drain();
    report_test(errors_before);
  endtask

  task automatic test_random(input string name, input int stall_sel, input int ready_sel);
    int errors_before;
    errors_before = error_count;
    test_name = name;
    stall_mode <= stall_sel;
    ready_mode <= ready_sel;
    repeat (200)
      send_pair($urandom, $urandom);
    wait_drain();
    stall_mode <= 0;
    ready_mode <= 0;
    wait_drain();
    report_test(errors_before);
  endtask

  task automatic test_capacity();
    int errors_before;
    int accepted;
    int low_run;
    int t;
    errors_before = error_count;
    test_name = "capacity";
    ready_mode <= 2;
    repeat (2) @(posedge clk);
    in_valid <= 1'b1;
    in_left  <= $urandom;
    in_right <= $urandom;
    accepted = 0;
    low_run = 0;
    t = 0;
    while (low_run < 10 && t < TIMEOUT)
    begin
      @(posedge clk);
      t++;
      if (in_ready)
      begin
        accepted++;
        low_run = 0;
        in_left  <= $urandom;
        in_right <= $urandom;
      end
      else
        low_run++;
    end
    in_valid <= 1'b0;
    if (low_run < 10)
      note_timeout("in_ready to stay low");
    check_count(accepted, 9, "accepted pairs");
    ready_mode <= 0;
    wait_drain();
    check_count(int'(out_valid), 0, "out_valid after drain");
    report_test(errors_before);
  endtask

  initial
  begin
    void'($urandom(562));
    rstnn    = 1'b0;
    in_valid = 1'b0;
    in_left  = '0;
    in_right = '0;
    repeat (10) @(posedge clk);
    rstnn <= 1'b1;
    repeat (2) @(posedge clk);

    test_corners();
    if (!timed_out)
      test_streaming();
    if (!timed_out)
      test_random("output back-pressure", 0, 1);
    if (!timed_out)
      test_random("stall", 1, 0);
    if (!timed_out)
      test_capacity();

    $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0 && !timed_out)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule
